// File: source/snd_cfg_pkg.sv
// Configuration register map, field types and reset values
`include "snd_config.svh"

package snd_cfg_pkg;

    // Register address and bit clock divider field
    typedef logic [1:0] cfg_addr_t;
    typedef logic [`SND_BCK_DIV_W-1:0] bck_div_t;

    // Register map
    localparam cfg_addr_t CFG_CTRL = 2'd0;
    localparam cfg_addr_t CFG_BCK  = 2'd1;

    // CTRL bit positions
    localparam int CTRL_SIGNED = 0;
    localparam int CTRL_STEREO = 1;
    localparam int CTRL_MUTE   = 2;

    // Values after reset: signed stereo input, not muted
    localparam logic CTRL_SIGNED_RST = 1'b1;
    localparam logic CTRL_STEREO_RST = 1'b1;
    localparam logic CTRL_MUTE_RST   = 1'b0;

    // Bit clock half-period after reset
    localparam bck_div_t BCK_DIV_RST = 4;

endpackage

// File: source/snd_cfg_regs.sv
// Write-only CTRL and BCK registers for the audio back end
module snd_cfg_regs (
    input  logic                  clk_dac,
    input  logic                  rst,
    input  logic                  cfg_wr,
    input  snd_cfg_pkg::cfg_addr_t cfg_addr,
    input  logic [7:0]            cfg_wdata,
    output logic                  in_signed,
    output logic                  stereo,
    output logic                  mute,
    output snd_cfg_pkg::bck_div_t bck_div
);
    import snd_cfg_pkg::*;

    logic wr_ctrl;
    logic wr_bck;

    // Address decode, other addresses fall through
    assign wr_ctrl = cfg_wr && (cfg_addr == CFG_CTRL);
    assign wr_bck  = cfg_wr && (cfg_addr == CFG_BCK);

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            in_signed <= CTRL_SIGNED_RST;
            stereo    <= CTRL_STEREO_RST;
            mute      <= CTRL_MUTE_RST;
        end else if (wr_ctrl) begin
            in_signed <= cfg_wdata[CTRL_SIGNED];
            stereo    <= cfg_wdata[CTRL_STEREO];
            mute      <= cfg_wdata[CTRL_MUTE];
        end
    end

    // Zero would stop the bit clock, so it becomes one
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            bck_div <= BCK_DIV_RST;
        end else if (wr_bck) begin
            if (cfg_wdata == 8'd0) begin
                bck_div <= bck_div_t'(1);
            end else begin
                bck_div <= bck_div_t'(cfg_wdata);
            end
        end
    end

endmodule

// File: source/snd_config.svh
// Build-time widths, DAC enable divider and I2S frame length
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// PCM sample width per channel
`define SND_PCM_W 16

// clk_dac cycles per sigma-delta enable
`define SND_CEN_DIV 4

// Bit clock periods in one I2S frame, both channels
`define SND_FRAME_BITS 32

// Width of the run-time bit clock divider field
`define SND_BCK_DIV_W 8

// Silence in offset binary
`define SND_MIDSCALE 16'h8000

`endif

// File: source/snd_i2s_tx.sv
// Left-justified I2S transmitter with run-time bit clock divider
`include "snd_config.svh"

module snd_i2s_tx (
    input  logic                  clk_dac,
    input  logic                  rst,
    input  snd_cfg_pkg::bck_div_t bck_div,
    input  snd_pkg::pcm_t         held_left,
    input  snd_pkg::pcm_t         held_right,
    input  logic                  held_valid,
    output logic                  take,
    output logic                  I2S_BCK,
    output logic                  I2S_LRCK,
    output logic                  I2S_DATA
);
    import snd_pkg::*;
    import snd_cfg_pkg::*;

    localparam int IDX_W  = $clog2(`SND_FRAME_BITS);
    localparam int WORD_W = 2 * `SND_PCM_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`SND_FRAME_BITS - 1);
    localparam logic [IDX_W-1:0] HALF_IDX = IDX_W'(`SND_FRAME_BITS / 2);

    bck_div_t          hcnt;
    logic [IDX_W-1:0]  bit_idx;
    logic [IDX_W-1:0]  next_idx;
    logic [WORD_W-1:0] shreg;
    pcm_t              last_left;
    pcm_t              last_right;
    pcm_t              next_left;
    pcm_t              next_right;
    logic              tick;
    logic              fall;
    logic              frame_start;

    // >= covers a divider that shrinks while counting
    assign tick        = hcnt >= (bck_div - bck_div_t'(1));
    assign fall        = tick & I2S_BCK;
    assign frame_start = fall & (bit_idx == LAST_IDX);
    assign next_idx    = (bit_idx == LAST_IDX) ? '0 : bit_idx + 1'b1;

    // Pulse in the cycle before the LRCK falling edge
    assign take = frame_start & held_valid;

    // Underrun repeats the previous pair
    assign next_left  = held_valid ? held_left : last_left;
    assign next_right = held_valid ? held_right : last_right;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            hcnt    <= '0;
            I2S_BCK <= 1'b0;
        end else if (tick) begin
            hcnt    <= '0;
            I2S_BCK <= ~I2S_BCK;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // First falling edge after reset opens a frame
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            bit_idx    <= LAST_IDX;
            I2S_LRCK   <= 1'b0;
            I2S_DATA   <= 1'b0;
            last_left  <= `SND_MIDSCALE;
            last_right <= `SND_MIDSCALE;
        end else if (fall) begin
            bit_idx  <= next_idx;
            I2S_LRCK <= next_idx >= HALF_IDX;
            if (frame_start) begin
                I2S_DATA   <= next_left[`SND_PCM_W-1];
                last_left  <= next_left;
                last_right <= next_right;
            end else begin
                I2S_DATA <= shreg[WORD_W-1];
            end
        end
    end

    // Remaining bits of the frame, MSB goes out first
    always_ff @(posedge clk_dac) begin
        if (frame_start) begin
            shreg <= {next_left[`SND_PCM_W-2:0], next_right, 1'b0};
        end else if (fall) begin
            shreg <= {shreg[WORD_W-2:0], 1'b0};
        end
    end

endmodule

// File: source/snd_out_top.sv
// Audio back end: configuration, sample stage, PWM DACs and I2S output
module snd_out_top (
    input  logic                   clk_dac,
    input  logic                   rst,
    input  logic                   cfg_wr,
    input  snd_cfg_pkg::cfg_addr_t cfg_addr,
    input  logic [7:0]             cfg_wdata,
    input  logic                   snd_valid,
    output logic                   snd_ready,
    input  snd_pkg::pcm_t          snd_left,
    input  snd_pkg::pcm_t          snd_right,
    output logic                   snd_pwm_left,
    output logic                   snd_pwm_right,
    output logic                   I2S_BCK,
    output logic                   I2S_LRCK,
    output logic                   I2S_DATA
);
    import snd_pkg::*;
    import snd_cfg_pkg::*;

    logic     in_signed;
    logic     stereo;
    logic     mute;
    bck_div_t bck_div;
    pcm_t     held_left;
    pcm_t     held_right;
    logic     held_valid;
    logic     take;

    snd_cfg_regs u_cfg (
        .clk_dac    ( clk_dac    ),
        .rst        ( rst        ),
        .cfg_wr     ( cfg_wr     ),
        .cfg_addr   ( cfg_addr   ),
        .cfg_wdata  ( cfg_wdata  ),
        .in_signed  ( in_signed  ),
        .stereo     ( stereo     ),
        .mute       ( mute       ),
        .bck_div    ( bck_div    )
    );

    snd_sample_stage u_stage (
        .clk_dac    ( clk_dac    ),
        .rst        ( rst        ),
        .snd_valid  ( snd_valid  ),
        .snd_ready  ( snd_ready  ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .in_signed  ( in_signed  ),
        .stereo     ( stereo     ),
        .mute       ( mute       ),
        .take       ( take       ),
        .held_left  ( held_left  ),
        .held_right ( held_right ),
        .held_valid ( held_valid )
    );

    // DACs and I2S share the take pulse, so both switch pairs together
    snd_pwm_dac u_dac (
        .clk_dac       ( clk_dac       ),
        .rst           ( rst           ),
        .take          ( take          ),
        .held_left     ( held_left     ),
        .held_right    ( held_right    ),
        .snd_pwm_left  ( snd_pwm_left  ),
        .snd_pwm_right ( snd_pwm_right )
    );

    snd_i2s_tx u_i2s (
        .clk_dac    ( clk_dac    ),
        .rst        ( rst        ),
        .bck_div    ( bck_div    ),
        .held_left  ( held_left  ),
        .held_right ( held_right ),
        .held_valid ( held_valid ),
        .take       ( take       ),
        .I2S_BCK    ( I2S_BCK    ),
        .I2S_LRCK   ( I2S_LRCK   ),
        .I2S_DATA   ( I2S_DATA   )
    );

endmodule

// File: source/snd_pkg.sv
// Sample and accumulator types for the audio back end
`include "snd_config.svh"

package snd_pkg;

    // One channel of PCM audio
    typedef logic [`SND_PCM_W-1:0] pcm_t;

    // Sigma-delta accumulator, top bit is the carry out
    typedef logic [`SND_PCM_W:0] dac_acc_t;

endpackage

// File: source/snd_pwm_dac.sv
// Clock enable ring and a pair of first-order sigma-delta 1-bit DACs
`include "snd_config.svh"

module snd_pwm_dac (
    input  logic          clk_dac,
    input  logic          rst,
    input  logic          take,
    input  snd_pkg::pcm_t held_left,
    input  snd_pkg::pcm_t held_right,
    output logic          snd_pwm_left,
    output logic          snd_pwm_right
);
    import snd_pkg::*;

    localparam int NCH = 2;
    localparam int DIV = `SND_CEN_DIV;
    localparam logic [DIV-1:0] RING_RST = {{(DIV-1){1'b0}}, 1'b1};

    logic [DIV-1:0] cen_ring;
    logic           cen;
    pcm_t           sample [NCH];
    dac_acc_t       acc    [NCH];

    // One-hot ring, enable once every DIV cycles
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_ring <= RING_RST;
        end else begin
            cen_ring <= {cen_ring[DIV-2:0], cen_ring[DIV-1]};
        end
    end

    assign cen = cen_ring[0];

    // Samples change only on a frame boundary
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            sample[0] <= `SND_MIDSCALE;
            sample[1] <= `SND_MIDSCALE;
        end else if (take) begin
            sample[0] <= held_left;
            sample[1] <= held_right;
        end
    end

    // Carry of each add is the output bit; the low part keeps the error
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            for (int ch = 0; ch < NCH; ch++) begin
                acc[ch] <= '0;
            end
        end else if (cen) begin
            for (int ch = 0; ch < NCH; ch++) begin
                acc[ch] <= {1'b0, acc[ch][`SND_PCM_W-1:0]} + {1'b0, sample[ch]};
            end
        end
    end

    assign snd_pwm_left  = acc[0][`SND_PCM_W];
    assign snd_pwm_right = acc[1][`SND_PCM_W];

endmodule

// File: source/snd_sample_stage.sv
// One-entry sample buffer with sign, mono and mute conversion on intake
`include "snd_config.svh"

module snd_sample_stage (
    input  logic          clk_dac,
    input  logic          rst,
    input  logic          snd_valid,
    output logic          snd_ready,
    input  snd_pkg::pcm_t snd_left,
    input  snd_pkg::pcm_t snd_right,
    input  logic          in_signed,
    input  logic          stereo,
    input  logic          mute,
    input  logic          take,
    output snd_pkg::pcm_t held_left,
    output snd_pkg::pcm_t held_right,
    output logic          held_valid
);
    import snd_pkg::*;

    localparam int MSB = `SND_PCM_W - 1;

    pcm_t right_src;
    pcm_t left_conv;
    pcm_t right_conv;
    logic accept;

    // Room only while the entry is empty
    assign snd_ready = ~held_valid;
    assign accept    = snd_valid & snd_ready;

    always_comb begin
        // Mono takes both channels from the left input
        right_src  = stereo ? snd_right : snd_left;
        // Two's complement to offset binary
        left_conv  = {snd_left[MSB] ^ in_signed, snd_left[MSB-1:0]};
        right_conv = {right_src[MSB] ^ in_signed, right_src[MSB-1:0]};
        if (mute) begin
            left_conv  = `SND_MIDSCALE;
            right_conv = `SND_MIDSCALE;
        end
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (accept) begin
            held_valid <= 1'b1;
        end else if (take) begin
            held_valid <= 1'b0;
        end
    end

    // Converted pair, settings are frozen at acceptance
    always_ff @(posedge clk_dac) begin
        if (accept) begin
            held_left  <= left_conv;
            held_right <= right_conv;
        end
    end

endmodule

// File: tb.f
+incdir+source
source/snd_pkg.sv
source/snd_cfg_pkg.sv
source/snd_cfg_regs.sv
source/snd_sample_stage.sv
source/snd_pwm_dac.sv
source/snd_i2s_tx.sv
source/snd_out_top.sv
tests/snd_assert.sv
tests/snd_tb.sv

// File: tests/snd_assert.sv
// Bound concurrent assertions on the sample handshake, the take pulse
// and the output levels during reset
module snd_assert (
    input logic clk_dac,
    input logic rst,
    input logic snd_valid,
    input logic snd_ready,
    input logic take,
    input logic snd_pwm_left,
    input logic snd_pwm_right,
    input logic I2S_BCK,
    input logic I2S_LRCK,
    input logic I2S_DATA
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Entry is full right after an accept
    ready_after_accept: assert property (
        @(posedge clk_dac) disable iff (rst)
        (snd_valid && snd_ready) |=> !snd_ready
    ) else begin
        fail_count++;
        $error("snd_ready still high on the cycle after an accept");
    end

    // One take per frame boundary
    take_single_cycle: assert property (
        @(posedge clk_dac) disable iff (rst)
        take |=> !take
    ) else begin
        fail_count++;
        $error("take high on two consecutive cycles");
    end

    outputs_low_in_reset: assert property (
        @(posedge clk_dac)
        rst |-> !(snd_pwm_left || snd_pwm_right || I2S_BCK || I2S_LRCK || I2S_DATA)
    ) else begin
        fail_count++;
        $error("an output is high while reset is asserted");
    end

endmodule

bind snd_out_top snd_assert i_snd_assert (
    .clk_dac       ( clk_dac       ),
    .rst           ( rst           ),
    .snd_valid     ( snd_valid     ),
    .snd_ready     ( snd_ready     ),
    .take          ( take          ),
    .snd_pwm_left  ( snd_pwm_left  ),
    .snd_pwm_right ( snd_pwm_right ),
    .I2S_BCK       ( I2S_BCK       ),
    .I2S_LRCK      ( I2S_LRCK      ),
    .I2S_DATA      ( I2S_DATA      )
);

// File: tests/snd_tb.sv
// Testbench for the audio back end: random stimulus, I2S and PWM capture,
// reference model of the sample path and checks
`include "snd_config.svh"

module snd_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import snd_pkg::*;
    import snd_cfg_pkg::*;

    localparam int N_STEREO  = 16;
    localparam int N_MONO    = 12;
    localparam int N_BURST   = 16;
    localparam int N_UNDER   = 4;
    localparam int N_MUTE    = 8;
    localparam int PWM_N     = 4096;
    localparam int FRAME_CYC = 2 * `SND_FRAME_BITS * BCK_DIV_RST;
    localparam int N_PAIRS   = N_STEREO + N_MONO + N_BURST + N_MUTE + 1;
    localparam int BUDGET    = (2 * N_PAIRS + N_UNDER + 8) * FRAME_CYC + PWM_N * `SND_CEN_DIV;
    localparam int LIMIT     = 4 * BUDGET;

    logic       clk_dac;
    logic       rst;
    logic       cfg_wr;
    cfg_addr_t  cfg_addr;
    logic [7:0] cfg_wdata;
    logic       snd_valid;
    logic       snd_ready;
    pcm_t       snd_left;
    pcm_t       snd_right;
    logic       snd_pwm_left;
    logic       snd_pwm_right;
    logic       I2S_BCK;
    logic       I2S_LRCK;
    logic       I2S_DATA;

    // Model of configuration and sample flow
    logic        m_signed;
    logic        m_stereo;
    logic        m_mute;
    int          m_bck;
    logic [31:0] pending [$];
    logic [31:0] frame_q [$];
    logic [31:0] last_pair;
    logic [31:0] acc_pair;
    logic        acc_next;
    logic        lrck_q;
    logic        bck_q;
    logic        bck_skip;
    logic        synced;
    int          half_cnt;
    int          errors;
    int          sent_cnt;
    int          acc_cnt;
    int          taken_cnt;
    int          frames_pushed;
    int          frames_checked;
    int          frames_due;
    int          cycles;
    int          total;
    // I2S capture
    logic        mon_lrck;
    logic        mon_in_frame;
    logic [31:0] mon_word;
    int          mon_bits;

    snd_out_top i_snd_out_top (
        .clk_dac       ( clk_dac       ),
        .rst           ( rst           ),
        .cfg_wr        ( cfg_wr        ),
        .cfg_addr      ( cfg_addr      ),
        .cfg_wdata     ( cfg_wdata     ),
        .snd_valid     ( snd_valid     ),
        .snd_ready     ( snd_ready     ),
        .snd_left      ( snd_left      ),
        .snd_right     ( snd_right     ),
        .snd_pwm_left  ( snd_pwm_left  ),
        .snd_pwm_right ( snd_pwm_right ),
        .I2S_BCK       ( I2S_BCK       ),
        .I2S_LRCK      ( I2S_LRCK      ),
        .I2S_DATA      ( I2S_DATA      )
    );

    initial begin
        clk_dac = 1'b0;
        forever #4 clk_dac = ~clk_dac;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
                         input int tol = 0);
        longint diff;
        diff = longint'(got) - longint'(exp);
        if (diff < 0) begin
            diff = -diff;
        end
        if ($isunknown(got) || diff > tol) begin
            errors++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // Expected held pair from the conversion rules
    function automatic logic [31:0] convert(input pcm_t l, input pcm_t r);
        pcm_t cl;
        pcm_t cr;
        cl = l;
        cr = m_stereo ? r : l;
        if (m_signed) begin
            cl[`SND_PCM_W-1] = ~cl[`SND_PCM_W-1];
            cr[`SND_PCM_W-1] = ~cr[`SND_PCM_W-1];
        end
        if (m_mute) begin
            cl = `SND_MIDSCALE;
            cr = `SND_MIDSCALE;
        end
        return {cl, cr};
    endfunction

    // Frame boundaries, accepts and the bit clock rate, seen between edges
    always @(negedge clk_dac) begin
        if (!rst) begin
            if (lrck_q && !I2S_LRCK) begin
                synced = 1'b1;
                if (pending.size() > 0) begin
                    last_pair = pending.pop_front();
                    taken_cnt++;
                end
                frame_q.push_back(last_pair);
                frames_pushed++;
            end
            lrck_q = I2S_LRCK;
            if (acc_next) begin
                pending.push_back(acc_pair);
                acc_cnt++;
            end
            check("snd_ready", snd_ready, pending.size() == 0);
            acc_next = snd_valid && snd_ready;
            acc_pair = convert(snd_left, snd_right);
            if (I2S_BCK !== bck_q) begin
                if (!bck_skip) begin
                    check("I2S_BCK half period", half_cnt, m_bck);
                end
                bck_skip = 1'b0;
                half_cnt = 1;
            end else begin
                half_cnt++;
            end
            bck_q = I2S_BCK;
        end
    end

    // Frame capture starts at the LRCK falling edge
    always @(posedge I2S_BCK) begin
        if (mon_lrck && !I2S_LRCK) begin
            mon_in_frame = 1'b1;
            mon_bits = 0;
        end
        mon_lrck = I2S_LRCK;
        if (mon_in_frame) begin
            check("I2S_LRCK", I2S_LRCK, mon_bits >= `SND_PCM_W);
            mon_word = {mon_word[30:0], I2S_DATA};
            mon_bits++;
            if (mon_bits == `SND_FRAME_BITS) begin
                mon_in_frame = 1'b0;
                if (frame_q.size() == 0) begin
                    errors++;
                    $display("ERROR t=%0t an I2S frame arrived with no expected pair", $time);
                end else begin
                    last_word_check(frame_q.pop_front());
                end
            end
        end
    end

    task automatic last_word_check(input logic [31:0] exp);
        check("I2S_DATA left", mon_word[31:16], exp[31:16]);
        check("I2S_DATA right", mon_word[15:0], exp[15:0]);
        frames_checked++;
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input logic [7:0] data);
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(posedge clk_dac);
        #1;
        cfg_wr = 1'b0;
        if (addr == CFG_CTRL) begin
            m_signed = data[CTRL_SIGNED];
            m_stereo = data[CTRL_STEREO];
            m_mute = data[CTRL_MUTE];
        end else if (addr == CFG_BCK) begin
            m_bck = (data == 8'd0) ? 1 : data;
            bck_skip = 1'b1;
        end
    endtask

    // Holds valid until the handshake edge, then leaves valid high
    task automatic send_pair(input pcm_t l, input pcm_t r);
        snd_valid = 1'b1;
        snd_left = l;
        snd_right = r;
        sent_cnt++;
        @(negedge clk_dac);
        while (!snd_ready) begin
            @(negedge clk_dac);
        end
        @(posedge clk_dac);
        #1;
    endtask

    task automatic idle(input int n);
        snd_valid = 1'b0;
        repeat (n) begin
            @(posedge clk_dac);
            #1;
        end
    endtask

    task automatic send_random(input int n, input bit gaps);
        repeat (n) begin
            send_pair(pcm_t'($urandom()), pcm_t'($urandom()));
            if (gaps) begin
                idle($urandom_range(0, 40));
            end
        end
        idle(0);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_pushed + n;
        while (frames_pushed < target) begin
            @(posedge clk_dac);
        end
        #1;
    endtask

    // Ones per enable period after the new pair reaches the DACs
    task automatic pwm_density(input logic [31:0] pair);
        int ones_l;
        int ones_r;
        int floor_l;
        int floor_r;
        ones_l = 0;
        ones_r = 0;
        floor_l = (PWM_N * pair[31:16]) >> `SND_PCM_W;
        floor_r = (PWM_N * pair[15:0]) >> `SND_PCM_W;
        while (taken_cnt < sent_cnt) begin
            @(negedge clk_dac);
        end
        repeat (`SND_CEN_DIV) @(negedge clk_dac);
        repeat (PWM_N) begin
            ones_l += snd_pwm_left;
            ones_r += snd_pwm_right;
            repeat (`SND_CEN_DIV) @(negedge clk_dac);
        end
        // In mono the model gives both channels the left sample
        check("snd_pwm_left ones", ones_l, floor_l, 1);
        check("snd_pwm_right ones", ones_r, floor_r, 1);
        @(posedge clk_dac);
        #1;
    endtask

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk_dac);
            cycles++;
        end
        $display("TIMEOUT: run did not finish within %0d clock cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(62820));
        rst = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = CFG_CTRL;
        cfg_wdata = 8'd0;
        snd_valid = 1'b0;
        snd_left = '0;
        snd_right = '0;
        m_signed = CTRL_SIGNED_RST;
        m_stereo = CTRL_STEREO_RST;
        m_mute = CTRL_MUTE_RST;
        m_bck = BCK_DIV_RST;
        last_pair = {`SND_MIDSCALE, `SND_MIDSCALE};
        acc_next = 1'b0;
        lrck_q = 1'b0;
        bck_q = 1'b0;
        bck_skip = 1'b1;
        synced = 1'b0;
        half_cnt = 0;
        errors = 0;
        sent_cnt = 0;
        acc_cnt = 0;
        taken_cnt = 0;
        frames_pushed = 0;
        frames_checked = 0;
        frames_due = 0;
        mon_lrck = 1'b0;
        mon_in_frame = 1'b0;
        mon_word = '0;
        mon_bits = 0;
        repeat (2) @(posedge clk_dac);
        #1;
        rst = 1'b0;
        wait (synced);
        @(posedge clk_dac);
        #1;
        send_random(N_STEREO, 1'b1);
        // Unsigned mono
        cfg_write(CFG_CTRL, 8'h00);
        send_random(N_MONO, 1'b1);
        // Back to signed stereo; address 3 is not decoded
        cfg_write(CFG_CTRL, 8'h03);
        cfg_write(cfg_addr_t'(3), 8'h07);
        send_random(N_BURST, 1'b0);
        wait_frames(N_UNDER + 1);
        cfg_write(CFG_BCK, 8'h00);
        cfg_write(CFG_CTRL, 8'h00);
        send_pair(pcm_t'($urandom()), pcm_t'($urandom()));
        idle(0);
        pwm_density(acc_pair);
        cfg_write(CFG_CTRL, 8'h07);
        send_random(N_MUTE, 1'b1);
        while (taken_cnt < sent_cnt) begin
            @(posedge clk_dac);
        end
        // Last pushed frame carries the final pair
        frames_due = frames_pushed;
        while (frames_checked < frames_due) begin
            @(posedge clk_dac);
        end
        check("accepted pairs", acc_cnt, sent_cnt);
        total = errors + i_snd_out_top.i_snd_assert.fail_count;
        $display("Run done: %0d check errors, %0d assertion failures, %0d frames checked",
                 errors, i_snd_out_top.i_snd_assert.fail_count, frames_checked);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
